/* rtl/gbm_params.svh */
`ifndef GBM_PARAMS_SVH
`define GBM_PARAMS_SVH

// Stream word width in bits
`define GBM_DATA_W 64

// Features per tuple, 16 bits each
`define GBM_MAX_FEATURES 16

// Tree levels, leaves included
`define GBM_MAX_DEPTH 4

// Trees held by one unit
`define GBM_MAX_TREES_PER_UNIT 8

// Node words per unit memory
`define GBM_NODE_MEM_DEPTH 128

`endif

/* rtl/gbm_stream_pkg.sv */
`include "gbm_params.svh"
`default_nettype none

package gbm_stream_pkg;

  // One beat of the sink or source stream
  typedef struct packed {
    logic [`GBM_DATA_W-1:0] tdata;
    logic                   tlast;
  } gbm_axis_t;

  // AXI4-Lite master to slave
  typedef struct packed {
    // Write address channel
    logic [31:0] awaddr;
    logic        awvalid;
    // Write data channel
    logic [31:0] wdata;
    logic        wvalid;
    // Write response channel
    logic        bready;
    // Read address channel
    logic [31:0] araddr;
    logic        arvalid;
    // Read data channel
    logic        rready;
  } gbm_axil_req_t;

  // AXI4-Lite slave to master
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
  } gbm_axil_rsp_t;

endpackage

`default_nettype wire

/* rtl/gbm_model_pkg.sv */
`include "gbm_params.svh"
`default_nettype none

package gbm_model_pkg;

  // Node address width in a unit memory
  localparam int NODE_AW = $clog2(`GBM_NODE_MEM_DEPTH);

  // One stream word, seen as a tree node or as part of a tuple
  typedef union packed {
    struct packed {
      logic [7:0]         spare;
      logic signed [31:0] leaf;
      logic [15:0]        threshold;
      logic [7:0]         feature;
    } node;
    // Lowest feature in bits 15:0
    logic [3:0][15:0] feat;
  } gbm_line_u;

  // Model shape for one run
  typedef struct packed {
    logic [4:0]  num_features;
    logic [2:0]  tree_depth;
    logic [3:0]  trees_per_unit;
    logic [31:0] num_tuples;
  } gbm_cfg_t;

  // Tree word headed for one unit
  typedef struct packed {
    logic               en;
    logic [NODE_AW-1:0] addr;
    gbm_line_u          line;
  } gbm_node_wr_t;

  // Leaf sum of one unit for one tuple
  typedef struct packed {
    logic signed [31:0] sum;
  } gbm_partial_t;

endpackage

`default_nettype wire

/* rtl/gbm_ctrl_slave.sv */
`default_nettype none

module gbm_ctrl_slave (
  input  logic                          aclk,
  input  logic                          aresetn,
  input  gbm_stream_pkg::gbm_axil_req_t axil_req,
  output gbm_stream_pkg::gbm_axil_rsp_t axil_rsp,
  input  logic                          idle,
  output gbm_model_pkg::gbm_cfg_t       cfg,
  output logic                          start
);

  logic        wr_fire;
  logic        rd_fire;
  logic [2:0]  wr_sel;
  logic [2:0]  rd_sel;
  logic        bvalid_q;
  logic        rvalid_q;
  logic [31:0] rdata_q;

  ////////////////////////////////////////////////////////////
  // Handshake

  // Address and data taken together, no response pending
  assign wr_fire = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
  assign rd_fire = axil_req.arvalid && !rvalid_q;

  // Word index within the register map
  assign wr_sel = axil_req.awaddr[4:2];
  assign rd_sel = axil_req.araddr[4:2];

  always_comb begin
    axil_rsp         = '0;
    axil_rsp.awready = wr_fire;
    axil_rsp.wready  = wr_fire;
    axil_rsp.bvalid  = bvalid_q;
    axil_rsp.arready = !rvalid_q;
    axil_rsp.rvalid  = rvalid_q;
    axil_rsp.rdata   = rdata_q;
    // OKAY on both response channels
    axil_rsp.bresp   = 2'b00;
    axil_rsp.rresp   = 2'b00;
  end

  ////////////////////////////////////////////////////////////
  // Register file

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
      start    <= 1'b0;
      cfg      <= '0;
    end else begin
      // Start only honoured while the engine is idle
      start <= wr_fire && (wr_sel == 3'd0) && axil_req.wdata[0] && idle;

      // Response held until the master takes it
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (axil_req.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (axil_req.rready) begin
        rvalid_q <= 1'b0;
      end

      if (wr_fire) begin
        case (wr_sel)
          3'd1: cfg.num_features   <= axil_req.wdata[4:0];
          3'd2: cfg.tree_depth     <= axil_req.wdata[2:0];
          3'd3: cfg.trees_per_unit <= axil_req.wdata[3:0];
          3'd4: cfg.num_tuples     <= axil_req.wdata;
          default: ;
        endcase
      end
    end
  end

  // Read data, start bit reads back as zero
  always_ff @(posedge aclk) begin
    if (rd_fire) begin
      case (rd_sel)
        3'd0: rdata_q <= {30'd0, idle, 1'b0};
        3'd1: rdata_q <= {27'd0, cfg.num_features};
        3'd2: rdata_q <= {29'd0, cfg.tree_depth};
        3'd3: rdata_q <= {28'd0, cfg.trees_per_unit};
        3'd4: rdata_q <= cfg.num_tuples;
        default: rdata_q <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/gbm_stream_reader.sv */
`include "gbm_params.svh"
`default_nettype none

module gbm_stream_reader (
  input  logic                        aclk,
  input  logic                        aresetn,
  input  gbm_model_pkg::gbm_cfg_t     cfg,
  input  logic                        start,
  input  gbm_stream_pkg::gbm_axis_t   sink,
  input  logic                        sink_valid,
  output logic                        sink_ready,
  output gbm_model_pkg::gbm_node_wr_t node_wr0,
  output gbm_model_pkg::gbm_node_wr_t node_wr1,
  output gbm_model_pkg::gbm_line_u    tuple,
  output logic                        tuple_valid,
  input  logic                        tuple_ready0,
  input  logic                        tuple_ready1,
  input  logic                        out_done,
  output logic                        idle
);

  import gbm_model_pkg::*;

  localparam int NIDX_W = `GBM_MAX_DEPTH;

  typedef enum logic [2:0] {IDLE, READ_TREES, WAIT_TREES, READ_DATA, DRAIN} state_t;

  state_t             state;
  logic               fire;
  logic               tree_fire;
  logic               last_node;
  logic               sel;
  logic [NIDX_W-1:0]  node_idx;
  logic [NODE_AW-1:0] addr0;
  logic [NODE_AW-1:0] addr1;

  // Tree words never stall, tuples wait for both units
  assign sink_ready = (state == READ_TREES) ||
                      (state == READ_DATA && tuple_ready0 && tuple_ready1);
  assign fire       = sink_valid && sink_ready;
  assign tree_fire  = fire && (state == READ_TREES);

  // Final node of a tree of 2^depth - 1 words
  assign last_node = node_idx == NIDX_W'((1 << cfg.tree_depth) - 2);

  ////////////////////////////////////////////////////////////
  // Phase FSM

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state    <= IDLE;
      node_idx <= '0;
      sel      <= 1'b0;
      addr0    <= '0;
      addr1    <= '0;
    end else begin
      case (state)
        IDLE:       if (start) state <= READ_TREES;
        READ_TREES: if (fire && sink.tlast) state <= WAIT_TREES;
        WAIT_TREES: state <= READ_DATA;
        READ_DATA:  if (fire && sink.tlast) state <= DRAIN;
        DRAIN:      if (out_done) state <= IDLE;
        default:    state <= IDLE;
      endcase

      // Tree routing, even trees to unit 0, odd trees to unit 1
      if (start) begin
        node_idx <= '0;
        sel      <= 1'b0;
        addr0    <= '0;
        addr1    <= '0;
      end else if (tree_fire) begin
        if (sel) begin
          addr1 <= addr1 + 1'b1;
        end else begin
          addr0 <= addr0 + 1'b1;
        end
        if (last_node) begin
          node_idx <= '0;
          sel      <= !sel;
        end else begin
          node_idx <= node_idx + 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Unit side

  always_comb begin
    node_wr0.en   = tree_fire && !sel;
    node_wr0.addr = addr0;
    node_wr0.line = sink.tdata;
    node_wr1.en   = tree_fire && sel;
    node_wr1.addr = addr1;
    node_wr1.line = sink.tdata;
  end

  // Same tuple word to both units
  assign tuple       = sink.tdata;
  assign tuple_valid = fire && (state == READ_DATA);

  // Busy already in the start cycle
  assign idle = (state == IDLE) && !start;

endmodule

`default_nettype wire

/* rtl/gbm_tree_unit.sv */
`include "gbm_params.svh"
`default_nettype none

module gbm_tree_unit (
  input  logic                        aclk,
  input  logic                        aresetn,
  input  gbm_model_pkg::gbm_cfg_t     cfg,
  input  gbm_model_pkg::gbm_node_wr_t node_wr,
  input  gbm_model_pkg::gbm_line_u    tuple,
  input  logic                        tuple_valid,
  output logic                        tuple_ready,
  output gbm_model_pkg::gbm_partial_t part,
  output logic                        part_valid,
  input  logic                        part_ready
);

  import gbm_model_pkg::*;

  localparam int FIDX_W = $clog2(`GBM_MAX_FEATURES);
  localparam int LVL_W  = $clog2(`GBM_MAX_DEPTH);
  localparam int TREE_W = $clog2(`GBM_MAX_TREES_PER_UNIT) + 1;
  localparam int NIDX_W = `GBM_MAX_DEPTH;

  typedef enum logic [1:0] {LOAD, WALK, DONE} state_t;

  gbm_line_u                          mem [`GBM_NODE_MEM_DEPTH];
  logic [`GBM_MAX_FEATURES-1:0][15:0] feat;
  gbm_line_u                          cur;
  state_t                             state;
  logic [1:0]                         wcnt;
  logic [1:0]                         last_word;
  logic [LVL_W-1:0]                   level;
  logic [NIDX_W-1:0]                  idx;
  logic [TREE_W-1:0]                  tree;
  logic [NODE_AW-1:0]                 base;
  logic                               leaf_level;
  logic                               last_tree;
  logic                               go_right;
  logic                               res_free;
  logic signed [31:0]                 acc;

  // Four features per tuple word
  assign last_word  = 2'((cfg.num_features - 5'd1) >> 2);
  assign leaf_level = level == LVL_W'(cfg.tree_depth - 3'd1);
  assign last_tree  = tree == TREE_W'(cfg.trees_per_unit - 4'd1);

  // Trees packed back to back in node memory
  assign cur      = mem[base + NODE_AW'(idx)];
  // Unsigned compare, smaller goes left
  assign go_right = feat[cur.node.feature[FIDX_W-1:0]] >= cur.node.threshold;

  // Result slot empty or emptied this cycle
  assign res_free    = !part_valid || part_ready;
  assign tuple_ready = state == LOAD;

  ////////////////////////////////////////////////////////////
  // Storage

  always_ff @(posedge aclk) begin
    if (node_wr.en) begin
      mem[node_wr.addr] <= node_wr.line;
    end
  end

  always_ff @(posedge aclk) begin
    if (tuple_valid && tuple_ready) begin
      feat[{wcnt, 2'b00} +: 4] <= tuple.feat;
    end
    // Leaf accumulator
    if (state == LOAD) begin
      acc <= '0;
    end else if (state == WALK && leaf_level) begin
      acc <= acc + cur.node.leaf;
    end
    if (state == DONE && res_free) begin
      part.sum <= acc;
    end
  end

  ////////////////////////////////////////////////////////////
  // Walker FSM

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state      <= LOAD;
      wcnt       <= '0;
      level      <= '0;
      idx        <= '0;
      tree       <= '0;
      base       <= '0;
      part_valid <= 1'b0;
    end else begin
      if (part_valid && part_ready) begin
        part_valid <= 1'b0;
      end
      case (state)
        LOAD: begin
          if (tuple_valid) begin
            if (wcnt == last_word) begin
              wcnt  <= '0;
              level <= '0;
              idx   <= '0;
              tree  <= '0;
              base  <= '0;
              state <= WALK;
            end else begin
              wcnt <= wcnt + 1'b1;
            end
          end
        end
        WALK: begin
          // One level per cycle, child 2i+1 or 2i+2
          if (leaf_level) begin
            level <= '0;
            idx   <= '0;
            tree  <= tree + 1'b1;
            base  <= base + NODE_AW'((1 << cfg.tree_depth) - 1);
            if (last_tree) state <= DONE;
          end else begin
            level <= level + 1'b1;
            idx   <= {idx[NIDX_W-2:0], 1'b1} + NIDX_W'(go_right);
          end
        end
        DONE: begin
          // Waits here while the previous sum is still held
          if (res_free) begin
            part_valid <= 1'b1;
            state      <= LOAD;
          end
        end
        default: state <= LOAD;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/gbm_score_combiner.sv */
`include "gbm_params.svh"
`default_nettype none

module gbm_score_combiner (
  input  logic                        aclk,
  input  logic                        aresetn,
  input  gbm_model_pkg::gbm_cfg_t     cfg,
  input  logic                        start,
  input  gbm_model_pkg::gbm_partial_t part0,
  input  gbm_model_pkg::gbm_partial_t part1,
  input  logic                        part_valid0,
  input  logic                        part_valid1,
  output logic                        part_ready0,
  output logic                        part_ready1,
  output gbm_stream_pkg::gbm_axis_t   src,
  output logic                        src_valid,
  input  logic                        src_ready,
  output logic                        out_done
);

  import gbm_model_pkg::*;

  gbm_partial_t total;
  logic         load;
  logic [31:0]  beat_cnt;

  // Both sums taken in one cycle into a free output slot
  assign load        = part_valid0 && part_valid1 && (!src_valid || src_ready);
  assign part_ready0 = load;
  assign part_ready1 = load;
  assign total.sum   = part0.sum + part1.sum;

  // Final beat of the run leaving
  assign out_done = src_valid && src_ready && src.tlast;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      src_valid <= 1'b0;
      beat_cnt  <= '0;
    end else begin
      if (load) begin
        src_valid <= 1'b1;
      end else if (src_ready) begin
        src_valid <= 1'b0;
      end
      // Beat count restarts with each run
      if (start) begin
        beat_cnt <= '0;
      end else if (load) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  // Output beat, score sign-extended to the word
  always_ff @(posedge aclk) begin
    if (load) begin
      src.tdata <= {{(`GBM_DATA_W-32){total.sum[31]}}, total.sum};
      src.tlast <= (beat_cnt + 32'd1) == cfg.num_tuples;
    end
  end

endmodule

`default_nettype wire

/* rtl/gbm_user_logic.sv */
`default_nettype none

module gbm_user_logic (
  input  logic                          aclk,
  input  logic                          aresetn,
  input  gbm_stream_pkg::gbm_axil_req_t axil_req,
  output gbm_stream_pkg::gbm_axil_rsp_t axil_rsp,
  input  gbm_stream_pkg::gbm_axis_t     sink,
  input  logic                          sink_valid,
  output logic                          sink_ready,
  output gbm_stream_pkg::gbm_axis_t     src,
  output logic                          src_valid,
  input  logic                          src_ready
);

  import gbm_model_pkg::*;

  gbm_cfg_t     cfg;
  logic         start;
  logic         idle;
  logic         out_done;
  gbm_node_wr_t node_wr0;
  gbm_node_wr_t node_wr1;
  gbm_line_u    tuple;
  logic         tuple_valid;
  logic         tuple_ready0;
  logic         tuple_ready1;
  gbm_partial_t part0;
  gbm_partial_t part1;
  logic         part_valid0;
  logic         part_valid1;
  logic         part_ready0;
  logic         part_ready1;

  ////////////////////////////////////////////////////////////
  // Control and input side

  gbm_ctrl_slave ctrl_slave_i (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .idle     (idle),
    .cfg      (cfg),
    .start    (start)
  );

  gbm_stream_reader stream_reader_i (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .cfg          (cfg),
    .start        (start),
    .sink         (sink),
    .sink_valid   (sink_valid),
    .sink_ready   (sink_ready),
    .node_wr0     (node_wr0),
    .node_wr1     (node_wr1),
    .tuple        (tuple),
    .tuple_valid  (tuple_valid),
    .tuple_ready0 (tuple_ready0),
    .tuple_ready1 (tuple_ready1),
    .out_done     (out_done),
    .idle         (idle)
  );

  ////////////////////////////////////////////////////////////
  // Tree units, even trees in unit 0

  gbm_tree_unit tree_unit0_i (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .cfg         (cfg),
    .node_wr     (node_wr0),
    .tuple       (tuple),
    .tuple_valid (tuple_valid),
    .tuple_ready (tuple_ready0),
    .part        (part0),
    .part_valid  (part_valid0),
    .part_ready  (part_ready0)
  );

  gbm_tree_unit tree_unit1_i (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .cfg         (cfg),
    .node_wr     (node_wr1),
    .tuple       (tuple),
    .tuple_valid (tuple_valid),
    .tuple_ready (tuple_ready1),
    .part        (part1),
    .part_valid  (part_valid1),
    .part_ready  (part_ready1)
  );

  ////////////////////////////////////////////////////////////
  // Output side

  gbm_score_combiner score_combiner_i (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .cfg         (cfg),
    .start       (start),
    .part0       (part0),
    .part1       (part1),
    .part_valid0 (part_valid0),
    .part_valid1 (part_valid1),
    .part_ready0 (part_ready0),
    .part_ready1 (part_ready1),
    .src         (src),
    .src_valid   (src_valid),
    .src_ready   (src_ready),
    .out_done    (out_done)
  );

endmodule

`default_nettype wire

/* testbench/gbm_assert.sv */
`default_nettype none

module gbm_assert (
  input logic                          aclk,
  input logic                          aresetn,
  input gbm_stream_pkg::gbm_axis_t     sink,
  input logic                          sink_valid,
  input logic                          sink_ready,
  input gbm_stream_pkg::gbm_axis_t     src,
  input logic                          src_valid,
  input logic                          src_ready,
  input gbm_stream_pkg::gbm_axil_req_t axil_req,
  input gbm_stream_pkg::gbm_axil_rsp_t axil_rsp
);

  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////////////////////////////////////////////
  // Stream handshakes

  // Stalled sink beat stays put
  sink_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    sink_valid && !sink_ready |=> sink_valid && $stable(sink))
    else $error("sink beat changed while stalled");

  // Stalled output beat stays put
  src_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    src_valid && !src_ready |=> src_valid && $stable(src))
    else $error("src beat changed while stalled");

  // Quiet ports right after reset
  reset_quiet: assert property (@(posedge aclk)
    !aresetn |=> !src_valid && !sink_ready)
    else $error("valid or ready high after reset");

  ////////////////////////////////////////////////////////////
  // AXI4-Lite

  // Write response held until taken
  bvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
    else $error("bvalid dropped before bready");

endmodule

bind gbm_user_logic gbm_assert gbm_assert_i (
  .aclk       (aclk),
  .aresetn    (aresetn),
  .sink       (sink),
  .sink_valid (sink_valid),
  .sink_ready (sink_ready),
  .src        (src),
  .src_valid  (src_valid),
  .src_ready  (src_ready),
  .axil_req   (axil_req),
  .axil_rsp   (axil_rsp)
);

`default_nettype wire

/* testbench/gbm_tb.sv */
`include "gbm_params.svh"
`default_nettype none

module gbm_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import gbm_stream_pkg::*;

  localparam int WAIT_LIMIT = 4000;
  localparam int MAX_TREES  = 2 * `GBM_MAX_TREES_PER_UNIT;
  localparam int MAX_NODES  = (1 << `GBM_MAX_DEPTH) - 1;
  localparam int MAX_TUPLES = 32;

  logic          aclk;
  logic          aresetn;
  gbm_axil_req_t axil_req;
  gbm_axil_rsp_t axil_rsp;
  gbm_axis_t     sink;
  logic          sink_valid;
  logic          sink_ready;
  gbm_axis_t     src;
  logic          src_valid;
  logic          src_ready;

  // Model of the current run, trees in stream order
  int unsigned node_feat [MAX_TREES][MAX_NODES];
  int unsigned node_thr  [MAX_TREES][MAX_NODES];
  int          node_leaf [MAX_TREES][MAX_NODES];
  int unsigned tup_feat  [MAX_TUPLES][`GBM_MAX_FEATURES];
  int          cur_depth;
  int          cur_tpu;

  // Expected output beats, oldest first
  logic [63:0] exp_data [$];
  logic        exp_last [$];

  int errors       = 0;
  int checks       = 0;
  int beats        = 0;
  bit timed_out    = 1'b0;
  bit backpressure = 1'b0;

  gbm_user_logic gbm_user_logic_i (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .axil_req   (axil_req),
    .axil_rsp   (axil_rsp),
    .sink       (sink),
    .sink_valid (sink_valid),
    .sink_ready (sink_ready),
    .src        (src),
    .src_valid  (src_valid),
    .src_ready  (src_ready)
  );

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  // Output ready, random while back-pressure is on
  initial begin : ready_drive
    src_ready = 1'b1;
    forever begin
      @(negedge aclk);
      if (backpressure) begin
        src_ready = 1'($urandom % 2);
      end else begin
        src_ready = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Reference model

  // Walk every tree, smaller feature goes left, sum the leaves
  function automatic int gbm_score(input int t);
    int sum;
    int idx;
    sum = 0;
    for (int tr = 0; tr < 2 * cur_tpu; tr++) begin
      idx = 0;
      for (int lvl = 0; lvl < cur_depth - 1; lvl++) begin
        if (tup_feat[t][node_feat[tr][idx]] < node_thr[tr][idx]) begin
          idx = 2 * idx + 1;
        end else begin
          idx = 2 * idx + 2;
        end
      end
      sum += node_leaf[tr][idx];
    end
    return sum;
  endfunction

  // Scores checked in order at each accepted beat
  initial begin : compare_proc
    logic [63:0] e_data;
    logic        e_last;
    forever begin
      @(posedge aclk);
      if (aresetn && src_valid && src_ready) begin
        beats++;
        if (exp_data.size() == 0) begin
          errors++;
          $display("Output beat at %0t with no score pending", $time);
        end else begin
          e_data = exp_data.pop_front();
          e_last = exp_last.pop_front();
          checks += 2;
          if (src.tdata !== e_data) begin
            errors++;
            $display("FAIL %0t src.tdata expected %h got %h", $time, e_data, src.tdata);
          end
          if (src.tlast !== e_last) begin
            errors++;
            $display("FAIL %0t src.tlast expected %b got %b", $time, e_last, src.tlast);
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Bus drivers

  task automatic flag_timeout(input string what);
    timed_out = 1'b1;
    errors++;
    $display("Timeout at %0t: %s", $time, what);
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    int waited;
    if (timed_out) return;
    @(negedge aclk);
    axil_req.awaddr  = addr;
    axil_req.awvalid = 1'b1;
    axil_req.wdata   = data;
    axil_req.wvalid  = 1'b1;
    waited = 0;
    @(posedge aclk);
    while (!(axil_rsp.awready && axil_rsp.wready) && waited < WAIT_LIMIT) begin
      @(posedge aclk);
      waited++;
    end
    @(negedge aclk);
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    axil_req.bready  = 1'b1;
    if (waited >= WAIT_LIMIT) flag_timeout("write address and data never accepted");
    waited = 0;
    @(posedge aclk);
    while (!axil_rsp.bvalid && waited < WAIT_LIMIT) begin
      @(posedge aclk);
      waited++;
    end
    if (waited >= WAIT_LIMIT) flag_timeout("no write response");
    checks++;
    if (axil_rsp.bresp !== 2'b00) begin
      errors++;
      $display("FAIL %0t bresp expected 00 got %b", $time, axil_rsp.bresp);
    end
    @(negedge aclk);
    axil_req.bready = 1'b0;
  endtask

  task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
    int waited;
    data = '0;
    if (timed_out) return;
    @(negedge aclk);
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    waited = 0;
    @(posedge aclk);
    while (!axil_rsp.arready && waited < WAIT_LIMIT) begin
      @(posedge aclk);
      waited++;
    end
    @(negedge aclk);
    axil_req.arvalid = 1'b0;
    axil_req.rready  = 1'b1;
    if (waited >= WAIT_LIMIT) flag_timeout("read address never accepted");
    waited = 0;
    @(posedge aclk);
    while (!axil_rsp.rvalid && waited < WAIT_LIMIT) begin
      @(posedge aclk);
      waited++;
    end
    if (waited >= WAIT_LIMIT) flag_timeout("no read data");
    data = axil_rsp.rdata;
    checks++;
    if (axil_rsp.rresp !== 2'b00) begin
      errors++;
      $display("FAIL %0t rresp expected 00 got %b", $time, axil_rsp.rresp);
    end
    @(negedge aclk);
    axil_req.rready = 1'b0;
  endtask

  task automatic check_reg(input logic [31:0] addr, input logic [31:0] exp, input string name);
    logic [31:0] got;
    read_reg(addr, got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  // Valid stays high from beat to beat
  task automatic send_beat(input logic [63:0] data, input logic last);
    int waited;
    if (timed_out) return;
    @(negedge aclk);
    sink.tdata = data;
    sink.tlast = last;
    sink_valid = 1'b1;
    waited     = 0;
    @(posedge aclk);
    while (!sink_ready && waited < WAIT_LIMIT) begin
      @(posedge aclk);
      waited++;
    end
    if (waited >= WAIT_LIMIT) flag_timeout("sink beat never accepted");
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequences

  task automatic make_model(input int nf, input int depth, input int tpu, input int ntup);
    cur_depth = depth;
    cur_tpu   = tpu;
    for (int tr = 0; tr < 2 * tpu; tr++) begin
      for (int n = 0; n < (1 << depth) - 1; n++) begin
        node_feat[tr][n] = $urandom % nf;
        node_thr[tr][n]  = $urandom % 65536;
        node_leaf[tr][n] = int'($urandom % 200001) - 100000;
      end
    end
    // Padding features past num_features stay zero
    for (int t = 0; t < ntup; t++) begin
      for (int f = 0; f < `GBM_MAX_FEATURES; f++) begin
        tup_feat[t][f] = (f < nf) ? $urandom % 65536 : 0;
      end
    end
  endtask

  task automatic run_test(input int num, input string name, input int nf, input int depth,
                          input int tpu, input int ntup, input bit bp);
    int          err0;
    int          nodes;
    int          words;
    int          waited;
    int          s;
    logic [63:0] word;
    logic [31:0] status;
    err0         = errors;
    nodes        = (1 << depth) - 1;
    words        = (nf + 3) / 4;
    beats        = 0;
    backpressure = bp;
    make_model(nf, depth, tpu, ntup);
    for (int t = 0; t < ntup; t++) begin
      s = gbm_score(t);
      exp_data.push_back({{32{s[31]}}, s});
      exp_last.push_back(t == ntup - 1);
    end
    write_reg(32'h04, nf);
    write_reg(32'h08, depth);
    write_reg(32'h0C, tpu);
    write_reg(32'h10, ntup);
    write_reg(32'h00, 32'h1);
    // Trees, tlast on the final node of the final tree
    for (int tr = 0; tr < 2 * tpu; tr++) begin
      for (int n = 0; n < nodes; n++) begin
        word = {8'h00, node_leaf[tr][n], node_thr[tr][n][15:0], node_feat[tr][n][7:0]};
        send_beat(word, (tr == 2 * tpu - 1) && (n == nodes - 1));
      end
    end
    // Tuples, four features per word, lowest first
    for (int t = 0; t < ntup; t++) begin
      for (int w = 0; w < words; w++) begin
        word = {tup_feat[t][4*w+3][15:0], tup_feat[t][4*w+2][15:0],
                tup_feat[t][4*w+1][15:0], tup_feat[t][4*w][15:0]};
        send_beat(word, (t == ntup - 1) && (w == words - 1));
      end
    end
    @(negedge aclk);
    sink_valid = 1'b0;
    waited     = 0;
    while (!timed_out && exp_data.size() != 0 && waited < WAIT_LIMIT) begin
      @(posedge aclk);
      waited++;
    end
    if (waited >= WAIT_LIMIT) flag_timeout("scores missing at the output");
    // Idle comes back once the final beat has left
    read_reg(32'h00, status);
    waited = 0;
    while (!timed_out && status[1] !== 1'b1 && waited < 20) begin
      read_reg(32'h00, status);
      waited++;
    end
    checks += 2;
    if (status[1] !== 1'b1) begin
      errors++;
      $display("Engine did not return to idle after test %0d", num);
    end
    if (beats != ntup) begin
      errors++;
      $display("Test %0d gave %0d output beats instead of %0d", num, beats, ntup);
    end
    $display("test %0d %s: %0d beats, %0d errors", num, name, beats, errors - err0);
  endtask

  initial begin : main_seq
    int          err0;
    void'($urandom(32'hb7a0_d8a2));
    aresetn    = 1'b0;
    axil_req   = '0;
    sink       = '0;
    sink_valid = 1'b0;
    repeat (10) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;

    // Register readback, idle set out of reset
    err0 = errors;
    check_reg(32'h00, 32'h2, "ctrl");
    write_reg(32'h00, 32'h0);
    write_reg(32'h04, 32'd13);
    write_reg(32'h08, 32'd3);
    write_reg(32'h0C, 32'd5);
    write_reg(32'h10, 32'h0001_2345);
    check_reg(32'h00, 32'h2, "ctrl");
    check_reg(32'h04, 32'd13, "num_features");
    check_reg(32'h08, 32'd3, "tree_depth");
    check_reg(32'h0C, 32'd5, "trees_per_unit");
    check_reg(32'h10, 32'h0001_2345, "num_tuples");
    $display("test 1 register readback: %0d errors", errors - err0);

    run_test(2, "depth 1 single tuple", 4, 1, 1, 1, 1'b0);
    run_test(3, "random run", 16, 4, 8, 20, 1'b0);
    run_test(4, "back-pressure", 16, 4, 8, 16, 1'b1);
    run_test(5, "second model", 5, 3, 3, 10, 1'b0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+rtl
rtl/gbm_stream_pkg.sv
rtl/gbm_model_pkg.sv
rtl/gbm_ctrl_slave.sv
rtl/gbm_stream_reader.sv
rtl/gbm_tree_unit.sv
rtl/gbm_score_combiner.sv
rtl/gbm_user_logic.sv
testbench/gbm_assert.sv
testbench/gbm_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module gbm_tb -f tb.f -o gbm_sim > build.log 2>&1 \
  || { cat build.log; echo "Regression failed" > sim.log; }
# A crash or a failed assertion counts as a failed run
test -f sim.log || ./obj_dir/gbm_sim > sim.log 2>&1 \
  || echo "Regression failed" >> sim.log
cat sim.log
grep -q "Regression failed" sim.log && exit 1
exit 0
